/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_current_logger -f src.f -o tb_sim || exit 1
sim_out="$(./obj_dir/tb_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTS PASSED" && echo "simulation passed" || {
    echo "simulation failed"; exit 1; }

/* src.f */
src/adc_pkg.sv
src/spi_byte_if.sv
src/spi_byte_master.sv
src/adc_sequencer.sv
src/range_selector.sv
src/frame_streamer.sv
src/current_logger_top.sv
verification/current_logger_props.sv
verification/tb_current_logger.sv

/* src/adc_pkg.sv */
// shared constants and types, all timing counted in cycles of the 240 mhz system clock
package adc_pkg;

    // spi timing, shared by both links
    localparam int CLKS_PER_HALF_BIT    = 6;      // 20 mhz sclk
    localparam int ADC_CS_INACTIVE_CLKS = 8;
    localparam int MCU_CS_INACTIVE_CLKS = 50;

    // conversion timing
    localparam int CONV_PERIOD       = 12000;     // 50 us between triggers
    localparam int CONVST_CLKS       = 20;        // convst held CONVST_CLKS+1 cycles
    localparam int SAMPLE_DELAY_CLKS = 90;        // covers the adc conversion time

    // adc transaction
    localparam int          ADC_WORD_BYTES  = 4;
    localparam logic [31:0] ADC_CONFIG_WORD = 32'hD014000B;  // 1.25x range, unipolar
    localparam int          CODE_BITS       = 18;

    // autorange hysteresis on the raw code
    localparam int RANGE_LIMIT_LOW  = 2100;
    localparam int RANGE_LIMIT_HIGH = 220000;

    // frame to the mcu
    localparam int SAMPLES_PER_FRAME = 8;
    localparam int FRAME_BYTES       = SAMPLES_PER_FRAME * 4;

    typedef logic [CODE_BITS-1:0] adc_code_t;

    // one-hot, ma in the top bit
    typedef enum logic [2:0] {
        RANGE_MA = 3'b100,
        RANGE_UA = 3'b010,
        RANGE_NA = 3'b001
    } range_t;

    // word as sent to the mcu, msb first
    typedef struct packed {
        logic      ma;
        logic      ua;
        logic      na;
        logic [10:0] zero;
        adc_code_t code;
    } sample_word_t;

    typedef logic [7:0] byte_count_t;  // burst length, holds FRAME_BYTES

endpackage

/* src/adc_sequencer.sv */
// ads8691 style flow, config word sent once after reset, a trigger while busy waits its turn
`timescale 1ns/1ns

module adc_sequencer import adc_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    spi_byte_if.client adc_bus,
    output logic      o_convst,
    output logic      o_cs_hold,        // low forces adc cs low
    output logic      o_sample_valid,
    output adc_code_t o_code
);

    typedef enum logic [1:0] {ST_READY, ST_SAMPLING, ST_ACQUIRING} seq_state_t;

    seq_state_t  r_state;
    logic [13:0] r_timer;
    logic        r_conv_pending;
    logic [6:0]  r_delay;
    logic        r_configured;
    logic [31:0] r_tx_word;
    logic [7:0]  r_tx_byte;
    logic        r_tx_dv;
    logic [2:0]  r_tx_idx;

    assign adc_bus.tx_count = byte_count_t'(ADC_WORD_BYTES);
    assign adc_bus.tx_byte  = r_tx_byte;
    assign adc_bus.tx_dv    = r_tx_dv;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state        <= ST_READY;
            r_timer        <= '0;
            r_conv_pending <= 1'b0;
            r_delay        <= '0;
            r_configured   <= 1'b0;
            r_tx_dv        <= 1'b0;
            r_tx_idx       <= '0;
            o_convst       <= 1'b0;
            o_cs_hold      <= 1'b1;
            o_sample_valid <= 1'b0;
        end else begin
            o_sample_valid <= 1'b0;
            r_tx_dv        <= 1'b0;
            case (r_state)
                ST_READY: begin
                    r_tx_word <= r_configured ? 32'd0 : ADC_CONFIG_WORD;
                    r_tx_idx  <= '0;
                    r_delay   <= '0;
                    if (r_conv_pending) begin
                        r_conv_pending <= 1'b0;
                        o_convst       <= 1'b1;
                        o_cs_hold      <= 1'b0;  // cs low ahead of convst
                        r_state        <= ST_SAMPLING;
                    end
                end
                ST_SAMPLING: begin
                    if (o_convst) begin
                        if (r_delay == 7'(CONVST_CLKS)) begin
                            o_convst  <= 1'b0;
                            o_cs_hold <= 1'b1;
                            r_delay   <= '0;
                        end else begin
                            r_delay <= r_delay + 7'd1;
                        end
                    end else if (r_delay == 7'(SAMPLE_DELAY_CLKS)) begin
                        r_state <= ST_ACQUIRING;  // conversion done
                    end else begin
                        r_delay <= r_delay + 7'd1;
                    end
                end
                ST_ACQUIRING: begin
                    if (!r_tx_dv && adc_bus.tx_ready && r_tx_idx != 3'(ADC_WORD_BYTES)) begin
                        r_tx_byte <= r_tx_word[31:24];  // msb first
                        r_tx_word <= {r_tx_word[23:0], 8'd0};
                        r_tx_idx  <= r_tx_idx + 3'd1;
                        r_tx_dv   <= 1'b1;
                        if (r_tx_idx == 3'(ADC_WORD_BYTES - 1)) begin
                            r_configured <= 1'b1;
                        end
                    end
                    if (adc_bus.rx_dv && adc_bus.rx_count == byte_count_t'(ADC_WORD_BYTES - 1)) begin
                        o_sample_valid <= 1'b1;  // all bytes in
                        r_state        <= ST_READY;
                    end
                end
                default: r_state <= ST_READY;
            endcase

            // free running trigger, after the fsm so a tick is never lost
            if (r_timer == 14'(CONV_PERIOD - 1)) begin
                r_timer        <= '0;
                r_conv_pending <= 1'b1;
            end else begin
                r_timer <= r_timer + 14'd1;
            end
        end
    end

    // code = byte 0, byte 1, top two bits of byte 2
    always_ff @(posedge i_clk) begin
        if (adc_bus.rx_dv) begin
            case (adc_bus.rx_count)
                8'd0:    o_code[17:10] <= adc_bus.rx_byte;
                8'd1:    o_code[9:2]   <= adc_bus.rx_byte;
                8'd2:    o_code[1:0]   <= adc_bus.rx_byte[7:6];
                default: ;  // last byte carries no code bits
            endcase
        end
    end

endmodule

/* src/current_logger_top.sv */
// clock comes from outside, mcu miso unused so the mcu link only transmits
`timescale 1ns/1ns

module current_logger_top import adc_pkg::*; (
    input  logic w_clk_240mhz,
    input  logic r_spi_master_adc_reset,   // active low, synchronous
    input  logic i_adc_miso,
    output logic o_adc_sclk,
    output logic o_adc_mosi,
    output logic o_adc_cs_n,
    output logic o_adc_convst,
    output logic o_mcu_sclk,
    output logic o_mcu_mosi,
    output logic o_mcu_cs_n,
    output logic o_range_ma,
    output logic o_range_ua,
    output logic o_range_na,
    output logic o_switch_ma,
    output logic o_switch_ua,
    output logic o_switch_na,
    output logic o_frame_ready
);

    spi_byte_if adc_bus ();
    spi_byte_if mcu_bus ();

    logic         w_adc_master_cs_n;
    logic         w_cs_hold;
    logic         w_sample_valid;
    adc_code_t    w_code;
    range_t       w_range;
    logic         w_word_valid;
    sample_word_t w_word;

    spi_byte_master #(.CS_INACTIVE_CLKS(ADC_CS_INACTIVE_CLKS)) i_adc_spi (
        .i_clk(w_clk_240mhz), .i_rst_n(r_spi_master_adc_reset), .bus(adc_bus),
        .o_sclk(o_adc_sclk), .o_mosi(o_adc_mosi), .o_cs_n(w_adc_master_cs_n),
        .i_miso(i_adc_miso)
    );

    spi_byte_master #(.CS_INACTIVE_CLKS(MCU_CS_INACTIVE_CLKS)) i_mcu_spi (
        .i_clk(w_clk_240mhz), .i_rst_n(r_spi_master_adc_reset), .bus(mcu_bus),
        .o_sclk(o_mcu_sclk), .o_mosi(o_mcu_mosi), .o_cs_n(o_mcu_cs_n),
        .i_miso(1'b0)  // no return data from the mcu
    );

    adc_sequencer i_adc_sequencer (
        .i_clk(w_clk_240mhz), .i_rst_n(r_spi_master_adc_reset), .adc_bus(adc_bus),
        .o_convst(o_adc_convst), .o_cs_hold(w_cs_hold),
        .o_sample_valid(w_sample_valid), .o_code(w_code)
    );

    range_selector i_range_selector (
        .i_clk(w_clk_240mhz), .i_rst_n(r_spi_master_adc_reset),
        .i_sample_valid(w_sample_valid), .i_code(w_code), .o_range(w_range),
        .o_word_valid(w_word_valid), .o_word(w_word)
    );

    frame_streamer i_frame_streamer (
        .i_clk(w_clk_240mhz), .i_rst_n(r_spi_master_adc_reset),
        .i_word_valid(w_word_valid), .i_word(w_word), .mcu_bus(mcu_bus),
        .o_frame_ready(o_frame_ready)
    );

    assign o_adc_cs_n = w_adc_master_cs_n & w_cs_hold;  // either one pulls cs low

    // power transistors follow the range, analog switches are active low
    assign {o_range_ma, o_range_ua, o_range_na} = w_range;
    assign o_switch_ma = ~o_range_ma;
    assign o_switch_ua = ~o_range_ua;
    assign o_switch_na = ~o_range_na;

endmodule

/* src/frame_streamer.sv */
// no back pressure, a frame must finish streaming before the next one fills
`timescale 1ns/1ns

module frame_streamer import adc_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_word_valid,
    input  sample_word_t i_word,
    spi_byte_if.client   mcu_bus,
    output logic         o_frame_ready
);

    typedef logic [$clog2(SAMPLES_PER_FRAME)-1:0] word_idx_t;
    typedef logic [$clog2(FRAME_BYTES)-1:0]       byte_idx_t;

    logic [7:0] r_buf [2*FRAME_BYTES];  // two banks, bank bit on top
    logic       r_fill_bank;
    word_idx_t  r_wr_idx;
    byte_idx_t  r_rd_idx;
    logic       r_streaming;
    logic [7:0] r_tx_byte;
    logic       r_tx_dv;

    assign mcu_bus.tx_count = byte_count_t'(FRAME_BYTES);
    assign mcu_bus.tx_byte  = r_tx_byte;
    assign mcu_bus.tx_dv    = r_tx_dv;

    // word split into bytes, msb at the lowest address
    always_ff @(posedge i_clk) begin
        if (i_word_valid) begin
            for (int k = 0; k < 4; k++) begin
                r_buf[{r_fill_bank, r_wr_idx, 2'(k)}] <= i_word[8*(3-k) +: 8];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_fill_bank   <= 1'b0;
            r_wr_idx      <= '0;
            r_rd_idx      <= '0;
            r_streaming   <= 1'b0;
            r_tx_dv       <= 1'b0;
            o_frame_ready <= 1'b0;
        end else begin
            o_frame_ready <= 1'b0;
            r_tx_dv       <= 1'b0;
            if (i_word_valid) begin
                if (r_wr_idx == word_idx_t'(SAMPLES_PER_FRAME - 1)) begin
                    r_wr_idx      <= '0;
                    r_fill_bank   <= ~r_fill_bank;  // swap, full bank goes out
                    r_rd_idx      <= '0;
                    r_streaming   <= 1'b1;
                    o_frame_ready <= 1'b1;
                end else begin
                    r_wr_idx <= r_wr_idx + 1'b1;
                end
            end
            // stream bank is the one not being filled
            if (r_streaming && !r_tx_dv && mcu_bus.tx_ready) begin
                r_tx_byte   <= r_buf[{~r_fill_bank, r_rd_idx}];
                r_tx_dv     <= 1'b1;
                r_rd_idx    <= r_rd_idx + 1'b1;
                r_streaming <= r_rd_idx != byte_idx_t'(FRAME_BYTES - 1);
            end
        end
    end

endmodule

/* src/range_selector.sv */
// one range step per sample at most, word carries the range in force when the code was taken
`timescale 1ns/1ns

module range_selector import adc_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_sample_valid,
    input  adc_code_t    i_code,
    output range_t       o_range,
    output logic         o_word_valid,
    output sample_word_t o_word
);

    logic w_high;
    logic w_low;

    assign w_high = i_code >= adc_code_t'(RANGE_LIMIT_HIGH);  // near full scale
    assign w_low  = i_code <= adc_code_t'(RANGE_LIMIT_LOW);   // too little signal

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_range      <= RANGE_MA;  // widest range is safe
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= i_sample_valid;
            if (i_sample_valid) begin
                case (o_range)
                    RANGE_NA: if (w_high) o_range <= RANGE_UA;
                    RANGE_UA: begin
                        if (w_high) begin
                            o_range <= RANGE_MA;
                        end else if (w_low) begin
                            o_range <= RANGE_NA;
                        end
                    end
                    RANGE_MA: if (w_low) o_range <= RANGE_UA;
                    default:  o_range <= RANGE_MA;
                endcase
            end
        end
    end

    // tag with the old range, same edge as the step
    always_ff @(posedge i_clk) begin
        if (i_sample_valid) begin
            o_word.ma   <= o_range[2];
            o_word.ua   <= o_range[1];
            o_word.na   <= o_range[0];
            o_word.zero <= '0;
            o_word.code <= i_code;
        end
    end

endmodule

/* src/spi_byte_if.sv */
// byte level handshake to an spi master, tx_dv only while tx_ready is high
`timescale 1ns/1ns

interface spi_byte_if import adc_pkg::*; ();

    byte_count_t tx_count;   // bytes per chip select
    logic [7:0]  tx_byte;
    logic        tx_dv;      // one cycle strobe
    logic        tx_ready;
    logic [7:0]  rx_byte;
    logic        rx_dv;      // once per received byte
    byte_count_t rx_count;   // index of rx_byte in the burst

    modport client (output tx_count, tx_byte, tx_dv,
                    input  tx_ready, rx_byte, rx_dv, rx_count);

    modport master (input  tx_count, tx_byte, tx_dv,
                    output tx_ready, rx_byte, rx_dv, rx_count);

endinterface

/* src/spi_byte_master.sv */
// spi mode 0 only, one chip select, tx_count is sampled on the first tx_dv of a burst
`timescale 1ns/1ns

module spi_byte_master import adc_pkg::*; #(
    parameter int CS_INACTIVE_CLKS = ADC_CS_INACTIVE_CLKS  // cs low tail and cs high gap
) (
    input  logic i_clk,
    input  logic i_rst_n,
    spi_byte_if.master bus,
    output logic o_sclk,
    output logic o_mosi,
    output logic o_cs_n,
    input  logic i_miso
);

    typedef enum logic [1:0] {CS_IDLE, CS_BURST, CS_HOLD, CS_GAP} cs_state_t;

    cs_state_t   r_state;
    byte_count_t r_left;      // bytes still to be requested
    byte_count_t r_rx_idx;
    logic [7:0]  r_gap_cnt;
    logic        r_cs_n;

    logic [4:0] r_edges;      // sclk edges left in the byte
    logic [3:0] r_half_cnt;
    logic       r_sclk;
    logic [7:0] r_tx_shift;
    logic [7:0] r_rx_shift;
    logic       r_rx_dv;

    // byte engine, 16 edges per byte
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_edges    <= '0;
            r_half_cnt <= '0;
            r_sclk     <= 1'b0;
            r_tx_shift <= '0;
            r_rx_shift <= '0;
            r_rx_dv    <= 1'b0;
        end else begin
            r_rx_dv <= 1'b0;
            if (bus.tx_dv) begin
                r_tx_shift <= bus.tx_byte;  // msb out right away, mode 0
                r_edges    <= 5'd16;
                r_half_cnt <= '0;
            end else if (r_edges != 5'd0) begin
                if (r_half_cnt == 4'(CLKS_PER_HALF_BIT - 1)) begin
                    r_half_cnt <= '0;
                    r_edges    <= r_edges - 5'd1;
                    r_sclk     <= ~r_sclk;
                    if (!r_sclk) begin
                        r_rx_shift <= {r_rx_shift[6:0], i_miso};  // rising, sample
                    end else if (r_edges != 5'd1) begin
                        r_tx_shift <= {r_tx_shift[6:0], 1'b0};    // falling, next bit
                    end
                    if (r_edges == 5'd1) begin
                        r_rx_dv <= 1'b1;  // last falling edge
                    end
                end else begin
                    r_half_cnt <= r_half_cnt + 4'd1;
                end
            end
        end
    end

    // chip select sequencing
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state   <= CS_IDLE;
            r_cs_n    <= 1'b1;
            r_left    <= '0;
            r_gap_cnt <= '0;
            r_rx_idx  <= '0;
        end else begin
            if (r_rx_dv) begin
                r_rx_idx <= r_rx_idx + 8'd1;
            end
            case (r_state)
                CS_IDLE: begin
                    if (bus.tx_dv) begin
                        r_cs_n   <= 1'b0;
                        r_left   <= bus.tx_count - 8'd1;
                        r_rx_idx <= '0;
                        r_state  <= CS_BURST;
                    end
                end
                CS_BURST: begin
                    if (bus.tx_dv) begin
                        r_left <= r_left - 8'd1;
                    end else if (r_edges == 5'd0 && r_left == 8'd0) begin
                        r_gap_cnt <= '0;
                        r_state   <= CS_HOLD;
                    end
                end
                CS_HOLD: begin  // cs still low after the last byte
                    if (r_gap_cnt == 8'(CS_INACTIVE_CLKS - 1)) begin
                        r_cs_n    <= 1'b1;
                        r_gap_cnt <= '0;
                        r_state   <= CS_GAP;
                    end else begin
                        r_gap_cnt <= r_gap_cnt + 8'd1;
                    end
                end
                CS_GAP: begin   // minimum cs high time
                    if (r_gap_cnt == 8'(CS_INACTIVE_CLKS - 1)) begin
                        r_state <= CS_IDLE;
                    end else begin
                        r_gap_cnt <= r_gap_cnt + 8'd1;
                    end
                end
            endcase
        end
    end

    assign bus.tx_ready = (r_state == CS_IDLE) ||
                          (r_state == CS_BURST && r_edges == 5'd0 && r_left != 8'd0);
    assign bus.rx_byte  = r_rx_shift;
    assign bus.rx_dv    = r_rx_dv;
    assign bus.rx_count = r_rx_idx;

    assign o_sclk = r_sclk;
    assign o_mosi = r_tx_shift[7];
    assign o_cs_n = r_cs_n;

endmodule

/* verification/current_logger_props.sv */
// watches top level outputs only, all checks off while reset is low
`timescale 1ns/1ns

module current_logger_props (
    input logic w_clk_240mhz,
    input logic r_spi_master_adc_reset,
    input logic o_range_ma,
    input logic o_range_ua,
    input logic o_range_na,
    input logic o_switch_ma,
    input logic o_switch_ua,
    input logic o_switch_na,
    input logic o_frame_ready,
    input logic o_mcu_cs_n
);

    // exactly one range transistor on
    a_range_onehot: assert property (@(posedge w_clk_240mhz)
        disable iff (!r_spi_master_adc_reset) $onehot({o_range_ma, o_range_ua, o_range_na}))
        else $error("range outputs not one-hot");

    a_switch_inverse: assert property (@(posedge w_clk_240mhz)
        disable iff (!r_spi_master_adc_reset)
        {o_switch_ma, o_switch_ua, o_switch_na} == ~{o_range_ma, o_range_ua, o_range_na})
        else $error("switch outputs do not mirror the range outputs");

    // new frame while the old one is still on the mcu link
    a_frame_overrun: assert property (@(posedge w_clk_240mhz)
        disable iff (!r_spi_master_adc_reset) $rose(o_frame_ready) |-> o_mcu_cs_n)
        else $error("frame completed while the mcu stream was still running");

endmodule

/* verification/tb_current_logger.sv */
// top level ports only, adc and mcu are mode 0 slave models, one sample per conversion period
`timescale 1ns/1ns

module tb_current_logger import adc_pkg::*; ();

    localparam int XFER_TIMEOUT  = 2 * CONV_PERIOD;  // clocks allowed per adc transaction
    localparam int BURST_TIMEOUT = 2 * CONV_PERIOD;

    logic w_clk_240mhz;
    logic r_spi_master_adc_reset;
    logic i_adc_miso = 1'b0;
    logic o_adc_sclk, o_adc_mosi, o_adc_cs_n, o_adc_convst;
    logic o_mcu_sclk, o_mcu_mosi, o_mcu_cs_n;
    logic o_range_ma, o_range_ua, o_range_na;
    logic o_switch_ma, o_switch_ua, o_switch_na;
    logic o_frame_ready;

    logic [31:0]  adc_q[$];        // words the adc answers with, one per transaction
    logic [31:0]  mosi_q[$];       // words the adc received
    logic [7:0]   mcu_byte_q[$];
    int           burst_len_q[$];  // bytes per mcu chip select
    sample_word_t exp_word_q[$];
    range_t       model_range = RANGE_MA;

    // slave model state, written only by the monitor
    int          xfer_count = 0;
    int          adc_bits = 0;
    logic [31:0] adc_word = '0;
    logic [31:0] adc_mosi = '0;
    int          mcu_bits = 0;
    int          burst_bytes = 0;
    logic [7:0]  mcu_shift = '0;
    int          convst_rises = 0;
    int          frame_ready_count = 0;
    int          monitor_errors = 0;
    logic        convst_seen = 1'b0;
    logic        adc_cs_q = 1'b1, adc_sclk_q = 1'b0, convst_q = 1'b0;
    logic        mcu_cs_q = 1'b1, mcu_sclk_q = 1'b0;

    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;

    current_logger_top i_current_logger_top (.*);

    bind current_logger_top current_logger_props i_current_logger_props (
        .w_clk_240mhz(w_clk_240mhz), .r_spi_master_adc_reset(r_spi_master_adc_reset),
        .o_range_ma(o_range_ma), .o_range_ua(o_range_ua), .o_range_na(o_range_na),
        .o_switch_ma(o_switch_ma), .o_switch_ua(o_switch_ua), .o_switch_na(o_switch_na),
        .o_frame_ready(o_frame_ready), .o_mcu_cs_n(o_mcu_cs_n)
    );

    initial begin
        w_clk_240mhz = 1'b0;
        forever #4 w_clk_240mhz = ~w_clk_240mhz;  // 8 ns period
    end

    // both slaves, sampled 1 ns after the edge when outputs have settled
    always @(posedge w_clk_240mhz) begin
        #1;
        if (adc_cs_q && !o_adc_cs_n) begin
            adc_bits = 0;  // also hit by the convst window, harmless
            adc_word = (xfer_count < adc_q.size()) ? adc_q[xfer_count] : 32'd0;
            i_adc_miso = adc_word[31];
        end else if (!o_adc_cs_n && o_adc_sclk && !adc_sclk_q) begin
            adc_mosi = {adc_mosi[30:0], o_adc_mosi};  // rising sclk
            adc_bits++;
        end else if (!o_adc_cs_n && !o_adc_sclk && adc_sclk_q && adc_bits < 32) begin
            i_adc_miso = adc_word[31 - adc_bits];     // next bit on the falling edge
        end
        if (o_adc_convst && !convst_q) begin
            convst_rises++;
            convst_seen = 1'b1;
        end
        if (o_adc_convst && !o_adc_cs_n && o_adc_sclk != adc_sclk_q) begin
            $display("[ERROR] %0t ns: adc sclk toggled while convst high", $time);
            monitor_errors++;
        end
        if (!adc_cs_q && o_adc_cs_n && adc_bits == 32) begin
            if (!convst_seen) begin
                $display("[ERROR] %0t ns: adc transaction without a convst pulse", $time);
                monitor_errors++;
            end
            convst_seen = 1'b0;
            mosi_q.push_back(adc_mosi);
            adc_bits = 0;
            xfer_count++;
        end
        // mcu side collects bytes only
        if (mcu_cs_q && !o_mcu_cs_n) begin
            mcu_bits = 0;
            burst_bytes = 0;
        end else if (!o_mcu_cs_n && o_mcu_sclk && !mcu_sclk_q) begin
            mcu_shift = {mcu_shift[6:0], o_mcu_mosi};
            mcu_bits++;
            if (mcu_bits == 8) begin
                mcu_byte_q.push_back(mcu_shift);
                mcu_bits = 0;
                burst_bytes++;
            end
        end
        if (!mcu_cs_q && o_mcu_cs_n) begin
            burst_len_q.push_back(burst_bytes);
        end
        if (o_frame_ready) begin
            frame_ready_count++;
        end
        adc_cs_q = o_adc_cs_n;
        adc_sclk_q = o_adc_sclk;
        convst_q = o_adc_convst;
        mcu_cs_q = o_mcu_cs_n;
        mcu_sclk_q = o_mcu_sclk;
    end

    function automatic int errors_now();
        return n_errors + monitor_errors;
    endfunction

    function automatic range_t current_range();
        return range_t'({o_range_ma, o_range_ua, o_range_na});
    endfunction

    // one step per sample, hysteresis band keeps the range
    function automatic range_t next_range(input range_t cur, input adc_code_t code);
        if (int'(code) >= RANGE_LIMIT_HIGH) begin
            return (cur == RANGE_NA) ? RANGE_UA : RANGE_MA;
        end
        if (int'(code) <= RANGE_LIMIT_LOW) begin
            return (cur == RANGE_MA) ? RANGE_UA : RANGE_NA;
        end
        return cur;
    endfunction

    function automatic adc_code_t in_band_code();
        return adc_code_t'(RANGE_LIMIT_LOW + 1 +
                           $urandom % (RANGE_LIMIT_HIGH - RANGE_LIMIT_LOW - 1));
    endfunction

    task automatic check_word(input sample_word_t got, input sample_word_t exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input range_t got, input range_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_adc_word(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_value(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_xfer(input int target);
        int n;
        n = 0;
        while (xfer_count < target && n < XFER_TIMEOUT) begin
            @(negedge w_clk_240mhz);
            n++;
        end
        if (xfer_count < target) begin
            $display("timeout: adc transaction %0d never finished", target);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic wait_bursts(input int target);
        int n;
        n = 0;
        while (burst_len_q.size() < target && n < BURST_TIMEOUT) begin
            @(negedge w_clk_240mhz);
            n++;
        end
        if (burst_len_q.size() < target) begin
            $display("timeout: mcu frame %0d never arrived", target);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    // queue one adc answer, predict its tagged word, wait for cs to rise
    task automatic run_sample(input adc_code_t code);
        sample_word_t w;
        w = '0;
        {w.ma, w.ua, w.na} = model_range;  // range in force at the sample
        w.code = code;
        exp_word_q.push_back(w);
        model_range = next_range(model_range, code);
        adc_q.push_back({code, 14'h1A5A});    // filler in the bits past the code
        wait_xfer(xfer_count + 1);
        check_range(current_range(), model_range, $sformatf("range after code %0d", code));
        // switches are active low copies of the range
        check_range(range_t'(~{o_switch_ma, o_switch_ua, o_switch_na}), model_range,
                    $sformatf("switches after code %0d", code));
    endtask

    task automatic check_frame(input int frame);
        sample_word_t got;
        int base;
        check_value(burst_len_q[frame], FRAME_BYTES, $sformatf("frame %0d length", frame));
        if (mcu_byte_q.size() >= (frame + 1) * FRAME_BYTES) begin
            for (int i = 0; i < SAMPLES_PER_FRAME; i++) begin
                base = (frame * SAMPLES_PER_FRAME + i) * 4;
                got = {mcu_byte_q[base], mcu_byte_q[base + 1],
                       mcu_byte_q[base + 2], mcu_byte_q[base + 3]};  // msb first
                check_word(got, exp_word_q[frame * SAMPLES_PER_FRAME + i],
                           $sformatf("frame %0d word %0d", frame, i));
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        n_tests++;
        if (errors_now() == errors_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors_now() - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors_now();
        check_level(o_adc_cs_n, 1'b1, "adc cs after reset");
        check_level(o_mcu_cs_n, 1'b1, "mcu cs after reset");
        check_level(o_adc_convst, 1'b0, "convst after reset");
        check_level(o_adc_sclk, 1'b0, "adc sclk after reset");
        check_level(o_mcu_sclk, 1'b0, "mcu sclk after reset");
        check_level(o_frame_ready, 1'b0, "frame ready after reset");
        check_level(o_range_ma, 1'b1, "ma range after reset");
        run_sample(in_band_code());
        run_sample(in_band_code());
        check_value(mosi_q.size(), 2, "adc transactions seen");
        if (mosi_q.size() >= 2) begin
            check_adc_word(mosi_q[0], ADC_CONFIG_WORD, "first adc mosi word");
            check_adc_word(mosi_q[1], 32'd0, "second adc mosi word");
        end
        report_test("reset_state", e0);
    endtask

    task automatic test_convst_timing();
        int e0;
        int rises0;
        e0 = errors_now();
        rises0 = convst_rises;
        run_sample(in_band_code());
        check_value(convst_rises - rises0, 1, "convst pulses per transaction");
        check_level(o_adc_convst, 1'b0, "convst between transactions");
        report_test("convst_timing", e0);
    endtask

    task automatic test_autorange();
        int e0;
        e0 = errors_now();
        run_sample(18'd250000);  // high in ma, stays
        run_sample(18'd1000);
        run_sample(18'd2100);    // low limit itself counts as low
        run_sample(18'd220000);  // high limit counts as high
        run_sample(18'd262143);
        run_sample(in_band_code());
        check_range(current_range(), RANGE_MA, "range after autorange sequence");
        report_test("autorange", e0);
    endtask

    task automatic test_frame_stream();
        int e0;
        e0 = errors_now();
        wait_bursts(1);
        check_value(frame_ready_count, 1, "frame ready pulses");
        check_frame(0);
        report_test("frame_stream", e0);
    endtask

    task automatic test_ping_pong();
        int e0;
        e0 = errors_now();
        while (exp_word_q.size() < 2 * SAMPLES_PER_FRAME) begin
            run_sample(adc_code_t'($urandom));  // any range, fresh codes
        end
        wait_bursts(2);
        check_value(frame_ready_count, 2, "frame ready pulses");
        check_frame(1);
        report_test("ping_pong", e0);
    endtask

    initial begin
        void'($urandom(44263));
        r_spi_master_adc_reset = 1'b0;
        repeat (5) @(posedge w_clk_240mhz);
        #1;
        r_spi_master_adc_reset = 1'b1;
        @(negedge w_clk_240mhz);
        test_reset_state();
        test_convst_timing();
        test_autorange();
        test_frame_stream();
        test_ping_pong();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors_now());
        if (errors_now() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
